/* logic/scan_config.svh */
// widths and offsets here must keep mid and row inside the 32-bit LAST and table word layout
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths

// luma sample
`define SCAN_PX_W 8
// column index, up to 2048 pixels per line
`define SCAN_COL_W 11
// row index, up to 1024 lines per frame
`define SCAN_ROW_W 10

////////////////////////////////////////////////////////////////////////////
// result table and apb map

`define SCAN_TABLE_ROWS 64
`define SCAN_APB_ADDR_W 12
`define SCAN_THRESH_RESET 128

// register offsets, byte addresses
`define SCAN_REG_CTRL 'h000
`define SCAN_REG_STATUS 'h004
`define SCAN_REG_LAST 'h008
`define SCAN_TABLE_BASE 'h100

`endif

/* logic/scan_pkg.sv */
// types follow the widths in the config header; fvh bit order is field, vertical, horizontal
`default_nettype none

`include "scan_config.svh"

package scan_pkg;

   // one luma sample from the camera
   typedef logic [`SCAN_PX_W-1:0] pixel_t;

   // pixel position inside a line, 0 at the first active pixel
   typedef logic [`SCAN_COL_W-1:0] col_t;

   // line position inside a frame
   typedef logic [`SCAN_ROW_W-1:0] row_t;

   // sync flags as the decoder delivers them
   //  f  field
   //  v  vertical blank, high between frames
   //  h  horizontal blank, high between lines
   typedef struct packed {
      logic f;
      logic v;
      logic h;
   } fvh_t;

   // apb byte address
   typedef logic [`SCAN_APB_ADDR_W-1:0] apb_addr_t;

endpackage

`default_nettype wire

/* logic/line_blur.sv */
// one 1-2-1 stage with exactly one cycle latency; history restarts on h, edge pixels repeat
`timescale 1ns/1ps
`default_nettype none

module line_blur (
   input  logic            clk,
   input  logic            rst_n,
   input  scan_pkg::pixel_t px_in,
   input  logic            dv_in,
   input  scan_pkg::fvh_t  fvh_in,
   output scan_pkg::pixel_t px_out,
   output logic            dv_out,
   output scan_pkg::fvh_t  fvh_out
);

   import scan_pkg::*;

   // two extra bits hold 4 x max sample plus rounding
   localparam int SUM_W = $bits(pixel_t) + 2;

   pixel_t           p1_q;
   pixel_t           p2_q;
   logic             hist_ok;
   logic             active;
   pixel_t           p1;
   pixel_t           p2;
   logic [SUM_W-1:0] sum;

   // a real pixel inside the visible part of a line
   assign active = dv_in & ~fvh_in.h & ~fvh_in.v;

   // at the left edge the missing neighbours take the current pixel
   assign p1 = hist_ok ? p1_q : px_in;
   assign p2 = hist_ok ? p2_q : px_in;

   // p[n-2] + 2*p[n-1] + p[n] + 2
   assign sum = {2'b00, p2} + {1'b0, p1, 1'b0} + {2'b00, px_in} + SUM_W'(2);

   ////////////////////////////////////////////////////////////////////////////
   // history of the current line

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hist_ok <= 1'b0;
      end else if (fvh_in.h) begin
         // horizontal blank, next active pixel is a left edge
         hist_ok <= 1'b0;
      end else if (active) begin
         hist_ok <= 1'b1;
      end
   end

   // samples only, no reset needed since hist_ok masks them
   always_ff @(posedge clk) begin
      if (active) begin
         p2_q <= p1;
         p1_q <= px_in;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // output register, keeps px, dv and fvh aligned

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dv_out  <= 1'b0;
         fvh_out <= '0;
      end else begin
         dv_out  <= dv_in;
         fvh_out <= fvh_in;
      end
   end

   // divide by four, rounded
   always_ff @(posedge clk) begin
      px_out <= sum[SUM_W-1:2];
   end

endmodule

`default_nettype wire

/* logic/line_sync_decode.sv */
// outputs lag dv/fvh by one cycle; a line only ends on h rising while v is low
`timescale 1ns/1ps
`default_nettype none

module line_sync_decode (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           dv,
   input  scan_pkg::fvh_t fvh,
   output logic           pix_valid,
   output scan_pkg::col_t col,
   output scan_pkg::row_t row,
   output logic           line_end,
   output logic           frame_start
);

   import scan_pkg::*;

   fvh_t fvh_q;
   col_t col_cnt;
   logic h_rise;
   logic v_rise;
   logic active;

   // edge detect against last cycle's flags
   assign h_rise = fvh.h & ~fvh_q.h;
   assign v_rise = fvh.v & ~fvh_q.v;

   assign active = dv & ~fvh.h & ~fvh.v;

   ////////////////////////////////////////////////////////////////////////////
   // events and column tracking

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fvh_q       <= '0;
         col_cnt     <= '0;
         pix_valid   <= 1'b0;
         line_end    <= 1'b0;
         frame_start <= 1'b0;
      end else begin
         fvh_q       <= fvh;
         pix_valid   <= active;
         // lines inside vertical blank do not count
         line_end    <= h_rise & ~fvh.v;
         frame_start <= v_rise;
         // column restarts in every blank period
         if (fvh.h || fvh.v) begin
            col_cnt <= '0;
         end else if (active) begin
            col_cnt <= col_cnt + 1'b1;
         end
      end
   end

   // column of the pixel marked by pix_valid
   always_ff @(posedge clk) begin
      if (active) begin
         col <= col_cnt;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // row counter
   // row holds the current index while line_end is high, steps the cycle after

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row <= '0;
      end else if (v_rise) begin
         row <= '0;
      end else if (line_end) begin
         row <= row + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/laser_midpoint.sv */
// px must arrive one cycle ahead of pix_valid/col, as the sync decoder delays its events by one
`timescale 1ns/1ps
`default_nettype none

module laser_midpoint (
   input  logic             clk,
   input  logic             rst_n,
   input  scan_pkg::pixel_t px,
   input  logic             pix_valid,
   input  scan_pkg::col_t   col,
   input  scan_pkg::row_t   row_in,
   input  logic             line_end,
   input  scan_pkg::pixel_t threshold,
   output logic             row_done,
   output scan_pkg::row_t   row_out,
   output logic             hit,
   output scan_pkg::col_t   mid
);

   import scan_pkg::*;

   logic                 bright_q;
   logic                 seen;
   col_t                 first_col;
   col_t                 last_col;
   logic [$bits(col_t):0] mid_sum;

   // one extra bit so first + last cannot wrap
   assign mid_sum = {1'b0, first_col} + {1'b0, last_col};

   ////////////////////////////////////////////////////////////////////////////
   // threshold stage
   // compare registered here, which lines it up with pix_valid and col

   always_ff @(posedge clk) begin
      bright_q <= (px >= threshold);
   end

   ////////////////////////////////////////////////////////////////////////////
   // segment tracking within the row

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         seen <= 1'b0;
      end else if (line_end) begin
         // start the next row clean
         seen <= 1'b0;
      end else if (pix_valid && bright_q) begin
         seen <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (pix_valid && bright_q) begin
         // first bright column opens the segment
         if (!seen) begin
            first_col <= col;
         end
         // a single bright pixel gives first == last
         last_col <= col;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // row result, one cycle after line_end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row_done <= 1'b0;
      end else begin
         row_done <= line_end;
      end
   end

   always_ff @(posedge clk) begin
      if (line_end) begin
         row_out <= row_in;
         hit     <= seen;
         // no laser in this row reports column 0
         mid     <= seen ? mid_sum[$bits(col_t):1] : '0;
      end
   end

endmodule

`default_nettype wire

/* logic/scan_result_regs.sv */
// zero-wait apb slave without pready/pslverr; only CTRL is writable, nothing is recorded while disabled
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module scan_result_regs (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  scan_pkg::apb_addr_t paddr,
   input  logic [31:0]         pwdata,
   input  logic                frame_start,
   input  logic                row_done,
   input  scan_pkg::row_t      row,
   input  logic                hit,
   input  scan_pkg::col_t      mid,
   output logic [31:0]         prdata,
   output scan_pkg::pixel_t    threshold,
   output logic                enable
);

   import scan_pkg::*;

   localparam int IDX_W = $clog2(`SCAN_TABLE_ROWS);
   // table spans 4 bytes per row
   localparam int TBL_BYTES = `SCAN_TABLE_ROWS * 4;

   logic [15:0]                rows_seen;
   logic [15:0]                frames_seen;
   col_t                       last_mid;
   logic                       last_hit;
   row_t                       last_row;
   col_t                       tbl_mid [`SCAN_TABLE_ROWS];
   row_t                       tbl_row [`SCAN_TABLE_ROWS];
   logic [`SCAN_TABLE_ROWS-1:0] tbl_hit;
   logic                       record;
   logic                       tbl_wr;
   logic [IDX_W-1:0]           wr_idx;
   apb_addr_t                  rd_off;
   logic                       in_table;
   logic [IDX_W-1:0]           rd_idx;
   logic                       apb_wr;

   // word layout shared by LAST and each table entry
   // mid in 10:0, hit in 16, row from bit 20
   function automatic logic [31:0] pack_entry(col_t m, logic h, row_t r);
      logic [31:0] word;
      word = '0;
      word[$bits(col_t)-1:0] = m;
      word[16] = h;
      word[20 +: $bits(row_t)] = r;
      return word;
   endfunction

   assign record = enable & row_done;
   // rows past the table still reach LAST
   assign tbl_wr = record & (row < `SCAN_TABLE_ROWS);
   assign wr_idx = row[IDX_W-1:0];

   assign apb_wr = psel & penable & pwrite;

   ////////////////////////////////////////////////////////////////////////////
   // CTRL

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         enable    <= 1'b0;
         threshold <= pixel_t'(`SCAN_THRESH_RESET);
      end else if (apb_wr && paddr == apb_addr_t'(`SCAN_REG_CTRL)) begin
         enable    <= pwdata[0];
         threshold <= pwdata[15:8];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // counters and LAST

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rows_seen   <= '0;
         frames_seen <= '0;
         last_mid    <= '0;
         last_hit    <= 1'b0;
         last_row    <= '0;
      end else if (enable) begin
         // new frame wins over a row finishing in the same cycle
         if (frame_start) begin
            frames_seen <= frames_seen + 1'b1;
            rows_seen   <= '0;
         end else if (row_done) begin
            rows_seen <= rows_seen + 1'b1;
         end
         if (row_done) begin
            last_mid <= mid;
            last_hit <= hit;
            last_row <= row;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // midpoint table
   // hit bits cleared on reset so unwritten rows read as no laser

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tbl_hit <= '0;
      end else if (tbl_wr) begin
         tbl_hit[wr_idx] <= hit;
      end
   end

   always_ff @(posedge clk) begin
      if (tbl_wr) begin
         tbl_mid[wr_idx] <= mid;
         tbl_row[wr_idx] <= row;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read mux, valid during the access phase

   assign rd_off   = paddr - apb_addr_t'(`SCAN_TABLE_BASE);
   assign in_table = (paddr >= apb_addr_t'(`SCAN_TABLE_BASE)) && (rd_off < TBL_BYTES);
   assign rd_idx   = rd_off[IDX_W+1:2];

   always_comb begin
      prdata = '0;
      if (in_table) begin
         prdata = pack_entry(tbl_mid[rd_idx], tbl_hit[rd_idx], tbl_row[rd_idx]);
      end else begin
         case (paddr)
            apb_addr_t'(`SCAN_REG_CTRL):   prdata = {16'h0000, threshold, 7'h00, enable};
            apb_addr_t'(`SCAN_REG_STATUS): prdata = {frames_seen, rows_seen};
            apb_addr_t'(`SCAN_REG_LAST):   prdata = pack_entry(last_mid, last_hit, last_row);
            // undefined offsets read zero
            default:                       prdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/laser_scan_top.sv */
// single clock, no back-pressure on the pixel stream; row results appear some cycles after h rises
`timescale 1ns/1ps
`default_nettype none

module laser_scan_top (
   input  logic                clk,
   input  logic                rst_n,
   input  scan_pkg::pixel_t    px,
   input  logic                dv,
   input  scan_pkg::fvh_t      fvh,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  scan_pkg::apb_addr_t paddr,
   input  logic [31:0]         pwdata,
   output logic [31:0]         prdata
);

   import scan_pkg::*;

   localparam int N_BLUR = 3;

   // index 0 is the camera, index N_BLUR the fully smoothed stream
   pixel_t px_s  [N_BLUR+1];
   logic   dv_s  [N_BLUR+1];
   fvh_t   fvh_s [N_BLUR+1];

   // decode stage outputs
   logic   pix_valid;
   col_t   col;
   row_t   row;
   logic   line_end;
   logic   frame_start;

   // execute stage outputs
   logic   row_done;
   row_t   row_out;
   logic   hit;
   col_t   mid;

   pixel_t threshold;

   assign px_s[0]  = px;
   assign dv_s[0]  = dv;
   assign fvh_s[0] = fvh;

   ////////////////////////////////////////////////////////////////////////////
   // noise filter, three cascaded blurs

   for (genvar i = 0; i < N_BLUR; i++) begin : g_blur
      line_blur u_blur (
         .clk     (clk),
         .rst_n   (rst_n),
         .px_in   (px_s[i]),
         .dv_in   (dv_s[i]),
         .fvh_in  (fvh_s[i]),
         .px_out  (px_s[i+1]),
         .dv_out  (dv_s[i+1]),
         .fvh_out (fvh_s[i+1])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // decode, execute, result

   line_sync_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .dv          (dv_s[N_BLUR]),
      .fvh         (fvh_s[N_BLUR]),
      .pix_valid   (pix_valid),
      .col         (col),
      .row         (row),
      .line_end    (line_end),
      .frame_start (frame_start)
   );

   // pixel taken straight from the last blur, one cycle ahead of the decoder
   laser_midpoint u_mid (
      .clk       (clk),
      .rst_n     (rst_n),
      .px        (px_s[N_BLUR]),
      .pix_valid (pix_valid),
      .col       (col),
      .row_in    (row),
      .line_end  (line_end),
      .threshold (threshold),
      .row_done  (row_done),
      .row_out   (row_out),
      .hit       (hit),
      .mid       (mid)
   );

   scan_result_regs u_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .frame_start (frame_start),
      .row_done    (row_done),
      .row         (row_out),
      .hit         (hit),
      .mid         (mid),
      .prdata      (prdata),
      .threshold   (threshold),
      .enable      ()
   );

endmodule

`default_nettype wire

/* verif/tb_scan_tasks.svh */
// included inside the testbench module; uses its signals, line buffer and model
`ifndef TB_SCAN_TASKS_SVH
`define TB_SCAN_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// apb, setup then access phase, no wait states

task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b1;
   paddr   <= addr;
   pwdata  <= data;
   @(posedge clk);
   penable <= 1'b1;
   @(posedge clk);
   psel    <= 1'b0;
   penable <= 1'b0;
   pwrite  <= 1'b0;
endtask

task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= 1'b0;
   paddr   <= addr;
   @(posedge clk);
   penable <= 1'b1;
   // prdata settled mid access phase
   @(negedge clk);
   data = prdata;
   @(posedge clk);
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

////////////////////////////////////////////////////////////////////////////
// pixel stream

// noise below 40, optionally one band of the given level
task automatic make_line(input int level, input bit with_band);
   int i;
   int width;
   int start;
   for (i = 0; i < LINE_PX; i++) begin
      line_px[i] = $urandom_range(39, 0);
   end
   if (with_band) begin
      width = $urandom_range(12, 5);
      start = $urandom_range(LINE_PX - width - 2, 2);
      for (i = start; i < start + width; i++) begin
         line_px[i] = level;
      end
   end
endtask

// active pixels with random idle cycles, then h blank
task automatic send_line();
   int i;
   for (i = 0; i < LINE_PX; i++) begin
      if ($urandom_range(7, 0) == 0) begin
         // idle cycle, bright junk that must be ignored
         @(posedge clk);
         px  <= 8'hFF;
         dv  <= 1'b0;
         fvh <= '{f: 1'b0, v: 1'b0, h: 1'b0};
      end
      @(posedge clk);
      px  <= pixel_t'(line_px[i]);
      dv  <= 1'b1;
      fvh <= '{f: 1'b0, v: 1'b0, h: 1'b0};
   end
   // h rising ends the line
   for (i = 0; i < LINE_BLANK; i++) begin
      @(posedge clk);
      px  <= '0;
      dv  <= 1'b0;
      fvh <= '{f: 1'b0, v: 1'b0, h: 1'b1};
   end
endtask

// vertical blank then rows; keep_line resends the last generated line
task automatic send_frame(input int n_rows, input int level, input int dark_row,
                          input int thr, input bit keep_line);
   int i;
   int r;
   for (i = 0; i < V_BLANK; i++) begin
      @(posedge clk);
      dv  <= 1'b0;
      fvh <= '{f: 1'b0, v: 1'b1, h: 1'b1};
   end
   for (r = 0; r < n_rows; r++) begin
      if (!keep_line) begin
         make_line(level, r != dark_row);
      end
      model_line(thr, r);
      send_line();
   end
endtask

`endif

/* verif/tb_laser_scan.sv */
// one clock, stream idles in h blank during apb access; needs a simulator with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module tb_laser_scan;

   import scan_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int LINE_PX    = 48;
   localparam int LINE_BLANK = 12;
   localparam int V_BLANK    = 6;
   localparam int MAX_ROWS   = 80;
   // rows and frames sent over the whole run
   localparam int ROWS_TOTAL = 8 + 1 + 1 + 4 + 66;
   localparam int FRAMES     = 5;
   // worst case one idle cycle per pixel, plus apb traffic and margin
   localparam int WATCHDOG_CYCLES = ROWS_TOTAL * (2 * LINE_PX + LINE_BLANK)
                                  + FRAMES * V_BLANK + 3 * 400 + 4000;

   logic        clk;
   logic        rst_n;
   pixel_t      px;
   logic        dv;
   fvh_t        fvh;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   int          errors;
   int          checks;
   // current line as sent, active pixels only
   int          line_px [LINE_PX];
   // model result per row of the frame in flight
   int          row_hit [MAX_ROWS];
   int          row_mid [MAX_ROWS];
   // what the register block should hold
   logic [31:0] tbl_exp [`SCAN_TABLE_ROWS];
   logic [31:0] last_exp;

   ////////////////////////////////////////////////////////////////////////////
   // reference model

   // mid 10:0, hit 16, row from 20
   function automatic logic [31:0] result_word(input int row, input int hit, input int mid);
      return (32'(row) << 20) | (32'(hit) << 16) | 32'(mid);
   endfunction

   function automatic logic [31:0] ctrl_word(input int en, input int thr);
      return (32'(thr) << 8) | 32'(en);
   endfunction

   // three 1-2-1 passes, left edge repeats pixel 0, then threshold and midpoint
   function automatic void model_line(input int thr, input int r);
      int a [LINE_PX];
      int b [LINE_PX];
      int first;
      int last;
      int n;
      int pass;
      a = line_px;
      for (pass = 0; pass < 3; pass++) begin
         for (n = 0; n < LINE_PX; n++) begin
            b[n] = (a[(n >= 2) ? n - 2 : 0] + 2 * a[(n >= 1) ? n - 1 : 0] + a[n] + 2) >> 2;
         end
         a = b;
      end
      first = -1;
      last  = 0;
      for (n = 0; n < LINE_PX; n++) begin
         if (a[n] >= thr) begin
            if (first < 0) begin
               first = n;
            end
            last = n;
         end
      end
      row_hit[r] = (first >= 0) ? 1 : 0;
      row_mid[r] = (first >= 0) ? (first + last) >> 1 : 0;
   endfunction

   `include "tb_scan_tasks.svh"

   ////////////////////////////////////////////////////////////////////////////
   // DUT and clock

   laser_scan_top UUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .px      (px),
      .dv      (dv),
      .fvh     (fvh),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // unmapped offsets around the register page and past the table read zero
   property unmapped_reads_zero;
      @(posedge clk) disable iff (!rst_n)
         (psel && penable && !pwrite && (paddr inside {12'h00C, 12'h0FC, 12'h200}))
            |-> (prdata == 32'h0);
   endproperty

   assert property (unmapped_reads_zero) else begin
      errors++;
      $display("FAILED at %t: unmapped address 0x%03h read 0x%08h", $time, paddr, prdata);
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks

   task automatic check_read(input int addr, input logic [31:0] exp, input string what);
      logic [31:0] got;
      apb_read(apb_addr_t'(addr), got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAILED at %t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   // poll STATUS until rows_seen reaches n, bounded
   task automatic wait_rows(input int n);
      logic [31:0] status;
      int          polls;
      polls = 0;
      apb_read(apb_addr_t'(`SCAN_REG_STATUS), status);
      while (status[15:0] != 16'(n) && polls < 50) begin
         polls++;
         apb_read(apb_addr_t'(`SCAN_REG_STATUS), status);
      end
      if (status[15:0] != 16'(n)) begin
         errors++;
         $display("rows_seen stuck at %0d, the DUT never reported %0d rows", status[15:0], n);
      end
   endtask

   // rows of a recorded frame, table only below its depth
   task automatic commit_rows(input int n);
      int r;
      for (r = 0; r < n; r++) begin
         last_exp = result_word(r, row_hit[r], row_mid[r]);
         if (r < `SCAN_TABLE_ROWS) begin
            tbl_exp[r] = last_exp;
         end
      end
   endtask

   task automatic check_table(input int n);
      int r;
      for (r = 0; r < n && r < `SCAN_TABLE_ROWS; r++) begin
         check_read(`SCAN_TABLE_BASE + 4 * r, tbl_exp[r], $sformatf("table entry %0d", r));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      $timeformat(-9, 0, " ns", 10);
      void'($urandom(43));
      clk      = 1'b0;
      rst_n    = 1'b0;
      px       = '0;
      dv       = 1'b0;
      fvh      = '{f: 1'b0, v: 1'b0, h: 1'b1};
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      errors   = 0;
      checks   = 0;
      last_exp = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);

      // reset values and unmapped reads
      check_read(`SCAN_REG_CTRL, ctrl_word(0, `SCAN_THRESH_RESET), "CTRL after reset");
      check_read(`SCAN_REG_STATUS, 32'h0, "STATUS after reset");
      check_read('h00C, 32'h0, "unmapped 0x00C");
      check_read('h0FC, 32'h0, "unmapped 0x0FC");
      check_read('h200, 32'h0, "unmapped 0x200");

      // bright band per row, row 5 dark
      apb_write(apb_addr_t'(`SCAN_REG_CTRL), ctrl_word(1, 128));
      send_frame(8, 220, 5, 128, 1'b0);
      wait_rows(8);
      commit_rows(8);
      check_read(`SCAN_REG_STATUS, {16'd1, 16'd8}, "STATUS after frame 1");
      check_table(8);
      check_read(`SCAN_REG_LAST, last_exp, "LAST after frame 1");

      // dim band below the reset threshold, then the same line at 80
      send_frame(1, 100, -1, 128, 1'b0);
      wait_rows(1);
      commit_rows(1);
      check_read(`SCAN_REG_STATUS, {16'd2, 16'd1}, "STATUS after dim frame");
      check_table(1);
      apb_write(apb_addr_t'(`SCAN_REG_CTRL), ctrl_word(1, 80));
      check_read(`SCAN_REG_CTRL, ctrl_word(1, 80), "CTRL readback");
      send_frame(1, 100, -1, 80, 1'b1);
      wait_rows(1);
      commit_rows(1);
      check_read(`SCAN_REG_STATUS, {16'd3, 16'd1}, "STATUS after threshold 80");
      check_table(1);

      // disabled, nothing may move
      apb_write(apb_addr_t'(`SCAN_REG_CTRL), ctrl_word(0, 128));
      send_frame(4, 220, -1, 128, 1'b0);
      repeat (LINE_BLANK) @(posedge clk);
      check_read(`SCAN_REG_STATUS, {16'd3, 16'd1}, "STATUS while disabled");
      check_table(4);
      check_read(`SCAN_REG_LAST, last_exp, "LAST while disabled");

      // new frame running past the table depth
      apb_write(apb_addr_t'(`SCAN_REG_CTRL), ctrl_word(1, 128));
      send_frame(66, 220, 3, 128, 1'b0);
      wait_rows(66);
      commit_rows(66);
      check_read(`SCAN_REG_STATUS, {16'd4, 16'd66}, "STATUS after long frame");
      check_table(`SCAN_TABLE_ROWS);
      check_read(`SCAN_REG_LAST, last_exp, "LAST after long frame");

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("errors so far: %0d", errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
+incdir+verif
logic/scan_pkg.sv
logic/line_blur.sv
logic/line_sync_decode.sv
logic/laser_midpoint.sv
logic/scan_result_regs.sv
logic/laser_scan_top.sv
verif/tb_laser_scan.sv

/* Bender.yml */
package:
  name: laser_scan

sources:
  # design, compile order matters for the package
  - include_dirs:
      - logic
    files:
      - logic/scan_pkg.sv
      - logic/line_blur.sv
      - logic/line_sync_decode.sv
      - logic/laser_midpoint.sv
      - logic/scan_result_regs.sv
      - logic/laser_scan_top.sv

  # testbench
  - target: test
    include_dirs:
      - logic
      - verif
    files:
      - verif/tb_laser_scan.sv
